// ==== rtl/exec_pkg.sv ====
package exec_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// Major opcodes handled by the execute stage, bits [6:0] of the word
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		type_r = 3'd0,
		type_i = 3'd1,
		type_s = 3'd2,
		type_b = 3'd3,
		type_u = 3'd4,
		type_j = 3'd5
	} instr_type_e;

	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_xor   = 4'd3,
		alu_or    = 4'd4,
		alu_srl   = 4'd5,
		alu_sra   = 4'd6,
		alu_sll   = 4'd7,
		alu_less  = 4'd8,
		alu_uless = 4'd9
	} alu_op_e;

	////////////////////////////////////////////////////////////////////////////
	// Control and CSR
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		state_idle  = 2'd0,
		state_exec  = 2'd1,
		state_write = 2'd2,
		state_ack   = 2'd3
	} ctrl_state_e;

	localparam logic [11:0] csr_scratch_addr = 12'h340; // mscratch

endpackage

// ==== rtl/exec_control.sv ====
`timescale 1ns/1ps

module exec_control (
	input  logic        clock,
	input  logic        reset,
	input  logic        req,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	input  logic [31:0] alu_val,
	input  logic [31:0] csr_old,
	input  logic        rd_write,
	input  logic        csr_en,
	input  logic        illegal_op,
	input  logic        jump_taken,
	input  logic [31:0] jump_pc,
	output logic        ack,
	output logic        commit,
	output logic        taken,
	output logic        illegal,
	output logic [31:0] instr_q,
	output logic [31:0] pc_q,
	output logic [31:0] wb_data,
	output logic [31:0] result,
	output logic [31:0] next_pc
);

	exec_pkg::ctrl_state_e state;

	// Write-back select, shared by the register file and the result register
	assign wb_data = !rd_write ? 32'b0 :
	                 csr_en    ? csr_old :
	                             alu_val;

	assign commit = (state == exec_pkg::state_write); // Writes land on the edge leaving this state

	// Request payload, captured once per transaction
	always_ff @(posedge clock) begin
		if (state == exec_pkg::state_idle && req) begin
			instr_q <= instr;
			pc_q    <= pc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= exec_pkg::state_idle;
			ack     <= 1'b0;
			result  <= 32'b0;
			next_pc <= 32'b0;
			taken   <= 1'b0;
			illegal <= 1'b0;
		end else begin
			case (state)
				exec_pkg::state_idle: begin
					if (req)
						state <= exec_pkg::state_exec;
				end
				exec_pkg::state_exec: begin
					state <= exec_pkg::state_write; // Decode and execute settle in this cycle
				end
				exec_pkg::state_write: begin
					result  <= wb_data;
					next_pc <= jump_pc;
					taken   <= jump_taken;
					illegal <= illegal_op;
					ack     <= 1'b1;
					state   <= exec_pkg::state_ack;
				end
				exec_pkg::state_ack: begin
					// Outputs stay frozen until the requester lets go of req
					if (!req) begin
						ack   <= 1'b0;
						state <= exec_pkg::state_idle;
					end
				end
				default: state <= exec_pkg::state_idle;
			endcase
		end
	end

	ack_in_ack_state: assert property (@(posedge clock) disable iff (reset)
		ack |-> (state == exec_pkg::state_ack));

	// The requester must hold req for the whole of a transaction
	req_held_in_flight: assert property (@(posedge clock) disable iff (reset)
		(state == exec_pkg::state_exec || state == exec_pkg::state_write) |-> req);

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
	input  logic                  [31:0] instr_q,
	output logic                  [4:0]  rs1,
	output logic                  [4:0]  rs2,
	output logic                  [4:0]  rd,
	output logic                  [31:0] imm,
	output exec_pkg::instr_type_e        itype,
	output exec_pkg::alu_op_e            alu_op,
	output exec_pkg::opcode_e            opcode,
	output logic                  [2:0]  funct3,
	output logic                  [11:0] csr_addr,
	output logic                         rd_write,
	output logic                         csr_en,
	output logic                         illegal_op
);

	logic alt; // funct7 bit 5, picks sub and sra

	assign opcode   = exec_pkg::opcode_e'(instr_q[6:0]);
	assign rd       = instr_q[11:7];
	assign funct3   = instr_q[14:12];
	assign rs1      = instr_q[19:15];
	assign rs2      = instr_q[24:20];
	assign csr_addr = instr_q[31:20];
	assign alt      = instr_q[30];

	// Format, write enables and legality from the major opcode
	always_comb begin
		itype      = exec_pkg::type_r;
		rd_write   = 1'b1;
		csr_en     = 1'b0;
		illegal_op = 1'b0;
		case (opcode)
			exec_pkg::op_lui,
			exec_pkg::op_auipc:  itype = exec_pkg::type_u;
			exec_pkg::op_jal:    itype = exec_pkg::type_j;
			exec_pkg::op_jalr,
			exec_pkg::op_imm:    itype = exec_pkg::type_i;
			exec_pkg::op_reg:    itype = exec_pkg::type_r;
			exec_pkg::op_branch: begin
				itype    = exec_pkg::type_b;
				rd_write = 1'b0;
			end
			exec_pkg::op_system: begin
				itype = exec_pkg::type_i;
				if (funct3 == 3'b001 || funct3 == 3'b010) begin
					csr_en = 1'b1; // csrrw or csrrs
				end else begin
					rd_write   = 1'b0;
					illegal_op = 1'b1;
				end
			end
			default: begin
				rd_write   = 1'b0;
				illegal_op = 1'b1;
			end
		endcase
	end

	// Sign-extended immediate per format
	always_comb begin
		case (itype)
			exec_pkg::type_i: imm = {{20{instr_q[31]}}, instr_q[31:20]};
			exec_pkg::type_s: imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
			exec_pkg::type_b: imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
			                         instr_q[30:25], instr_q[11:8], 1'b0};
			exec_pkg::type_u: imm = {instr_q[31:12], 12'b0};
			exec_pkg::type_j: imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
			                         instr_q[20], instr_q[30:21], 1'b0};
			default:          imm = 32'b0;
		endcase
	end

	always_comb begin
		alu_op = exec_pkg::alu_add; // Address and link arithmetic for the other formats
		if (itype == exec_pkg::type_i || itype == exec_pkg::type_r) begin
			case (funct3)
				3'b000: alu_op = (itype == exec_pkg::type_r && alt) ? exec_pkg::alu_sub
				                                                      : exec_pkg::alu_add;
				3'b001: alu_op = exec_pkg::alu_sll;
				3'b010: alu_op = exec_pkg::alu_less;
				3'b011: alu_op = exec_pkg::alu_uless;
				3'b100: alu_op = exec_pkg::alu_xor;
				3'b101: alu_op = alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
				3'b110: alu_op = exec_pkg::alu_or;
				default: alu_op = exec_pkg::alu_and;
			endcase
		end
	end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
	parameter int reg_count = 32
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        rd_write,
	input  logic        commit,
	input  logic [31:0] wdata,
	output logic [31:0] src1,
	output logic [31:0] src2
);

	localparam int addr_w = $clog2(reg_count);

	logic [31:0] regs [reg_count];

	// x0 and anything past the implemented registers read as zero
	assign src1 = (rs1 == 5'd0 || rs1 >= reg_count) ? 32'b0 : regs[rs1[addr_w-1:0]];
	assign src2 = (rs2 == 5'd0 || rs2 >= reg_count) ? 32'b0 : regs[rs2[addr_w-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= 32'b0;
		end else if (commit && rd_write && rd != 5'd0 && rd < reg_count) begin
			regs[rd[addr_w-1:0]] <= wdata;
		end
	end

	// An RV32E build must never see a destination in x16..x31
	rd_in_range: assert property (@(posedge clock) disable iff (reset)
		(commit && rd_write) |-> (rd < reg_count));

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
	input  exec_pkg::opcode_e        opcode,
	input  exec_pkg::alu_op_e        alu_op,
	input  logic              [31:0] src1,
	input  logic              [31:0] src2,
	input  logic              [31:0] imm,
	input  logic              [31:0] pc_q,
	output logic              [31:0] alu_val
);

	logic [31:0] lop;
	logic [31:0] rop;
	logic [31:0] diff;
	logic        borrow;
	logic        less;
	logic [4:0]  shamt;

	////////////////////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opcode)
			exec_pkg::op_lui:   lop = 32'b0;
			exec_pkg::op_auipc,
			exec_pkg::op_jal,
			exec_pkg::op_jalr:  lop = pc_q;
			default:            lop = src1;
		endcase
	end

	always_comb begin
		case (opcode)
			exec_pkg::op_lui,
			exec_pkg::op_auipc,
			exec_pkg::op_imm:   rop = imm;
			exec_pkg::op_jal,
			exec_pkg::op_jalr:  rop = 32'd4; // Link value is pc + 4
			default:            rop = src2;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////////////////////

	assign {borrow, diff} = {1'b0, lop} - {1'b0, rop};
	assign shamt = rop[4:0];

	// Signed compare: a negative left side wins, otherwise same signs use the difference
	assign less = (lop[31] & ~rop[31]) | (~(lop[31] ^ rop[31]) & diff[31]);

	always_comb begin
		case (alu_op)
			exec_pkg::alu_add:   alu_val = lop + rop;
			exec_pkg::alu_sub:   alu_val = diff;
			exec_pkg::alu_and:   alu_val = lop & rop;
			exec_pkg::alu_xor:   alu_val = lop ^ rop;
			exec_pkg::alu_or:    alu_val = lop | rop;
			exec_pkg::alu_srl:   alu_val = lop >> shamt;
			exec_pkg::alu_sra:   alu_val = $unsigned($signed(lop) >>> shamt);
			exec_pkg::alu_sll:   alu_val = lop << shamt;
			exec_pkg::alu_less:  alu_val = {31'b0, less};
			exec_pkg::alu_uless: alu_val = {31'b0, borrow}; // Borrow out means lop < rop
			default:             alu_val = 32'b0;
		endcase
	end

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  exec_pkg::opcode_e           opcode,
	input  exec_pkg::instr_type_e       itype,
	input  logic                 [2:0]  funct3,
	input  logic                 [31:0] src1,
	input  logic                 [31:0] src2,
	input  logic                 [31:0] imm,
	input  logic                 [31:0] pc_q,
	output logic                        jump_taken,
	output logic                 [31:0] jump_pc
);

	logic [31:0] diff;
	logic        borrow;
	logic        equal;
	logic        less;
	logic        cond;
	logic [31:0] base;

	assign {borrow, diff} = {1'b0, src1} - {1'b0, src2};
	assign equal = ~|diff;
	assign less  = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & diff[31]);

	always_comb begin
		case (funct3)
			3'b000:  cond = equal;   // beq
			3'b001:  cond = ~equal;  // bne
			3'b100:  cond = less;    // blt
			3'b101:  cond = ~less;   // bge
			3'b110:  cond = borrow;  // bltu
			3'b111:  cond = ~borrow; // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign jump_taken = (opcode == exec_pkg::op_jal) || (opcode == exec_pkg::op_jalr) ||
	                    (itype == exec_pkg::type_b && cond);

	// Only jalr is register relative
	assign base    = (itype == exec_pkg::type_i) ? src1 : pc_q;
	assign jump_pc = jump_taken ? base + imm : pc_q + 32'd4;

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
	input  logic        clock,
	input  logic        reset,
	input  logic        csr_en,
	input  logic        commit,
	input  logic [2:0]  funct3,
	input  logic [11:0] csr_addr,
	input  logic [31:0] src1,
	output logic [31:0] csr_old
);

	logic [31:0] scratch;
	logic        hit;

	assign hit     = (csr_addr == exec_pkg::csr_scratch_addr);
	assign csr_old = hit ? scratch : 32'b0; // Unimplemented CSRs read zero

	always_ff @(posedge clock) begin
		if (reset) begin
			scratch <= 32'b0;
		end else if (commit && csr_en && hit) begin
			case (funct3)
				3'b001:  scratch <= src1;           // csrrw
				3'b010:  scratch <= scratch | src1; // csrrs
				default: scratch <= scratch;
			endcase
		end
	end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
	parameter int reg_count = 32
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        req,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	output logic        ack,
	output logic [31:0] result,
	output logic [31:0] next_pc,
	output logic        taken,
	output logic        illegal
);

	logic [31:0]           instr_q;
	logic [31:0]           pc_q;
	logic                  commit;
	logic [31:0]           wb_data;
	logic [4:0]            rs1;
	logic [4:0]            rs2;
	logic [4:0]            rd;
	logic [31:0]           imm;
	exec_pkg::instr_type_e itype;
	exec_pkg::alu_op_e     alu_op;
	exec_pkg::opcode_e     opcode;
	logic [2:0]            funct3;
	logic [11:0]           csr_addr;
	logic                  rd_write;
	logic                  csr_en;
	logic                  illegal_op;
	logic [31:0]           src1;
	logic [31:0]           src2;
	logic [31:0]           alu_val;
	logic [31:0]           csr_old;
	logic                  jump_taken;
	logic [31:0]           jump_pc;

	////////////////////////////////////////////////////////////////////////////
	// Control and decode
	////////////////////////////////////////////////////////////////////////////

	exec_control control0 (
		.clock(clock), .reset(reset), .req(req), .instr(instr), .pc(pc),
		.alu_val(alu_val), .csr_old(csr_old), .rd_write(rd_write), .csr_en(csr_en),
		.illegal_op(illegal_op), .jump_taken(jump_taken), .jump_pc(jump_pc),
		.ack(ack), .commit(commit), .taken(taken), .illegal(illegal),
		.instr_q(instr_q), .pc_q(pc_q), .wb_data(wb_data),
		.result(result), .next_pc(next_pc)
	);

	instr_decode decode0 (
		.instr_q(instr_q), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.itype(itype), .alu_op(alu_op), .opcode(opcode), .funct3(funct3),
		.csr_addr(csr_addr), .rd_write(rd_write), .csr_en(csr_en),
		.illegal_op(illegal_op)
	);

	////////////////////////////////////////////////////////////////////////////
	// State and execution units
	////////////////////////////////////////////////////////////////////////////

	reg_file #(.reg_count(reg_count)) regs0 (
		.clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
		.rd_write(rd_write), .commit(commit), .wdata(wb_data),
		.src1(src1), .src2(src2)
	);

	alu_unit alu0 (
		.opcode(opcode), .alu_op(alu_op), .src1(src1), .src2(src2),
		.imm(imm), .pc_q(pc_q), .alu_val(alu_val)
	);

	branch_unit branch0 (
		.opcode(opcode), .itype(itype), .funct3(funct3), .src1(src1), .src2(src2),
		.imm(imm), .pc_q(pc_q), .jump_taken(jump_taken), .jump_pc(jump_pc)
	);

	csr_file csr0 (
		.clock(clock), .reset(reset), .csr_en(csr_en), .commit(commit),
		.funct3(funct3), .csr_addr(csr_addr), .src1(src1), .csr_old(csr_old)
	);

endmodule

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb;

	localparam int ack_timeout = 20; // Cycles allowed for each edge of ack

	logic        clock;
	logic        reset;
	logic        req;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        ack;
	logic [31:0] result;
	logic [31:0] next_pc;
	logic        taken;
	logic        illegal;

	int          errors;
	int          checks;
	logic [16:0] lfsr;

	// Stimulus and expected values with one entry per transaction
	logic [31:0] table_instr[$];
	logic [31:0] table_pc[$];
	logic [31:0] table_result[$];
	logic [31:0] table_next_pc[$];
	logic        table_taken[$];
	logic        table_illegal[$];

	exec_core #(.reg_count(32)) dut0 (
		.clock(clock), .reset(reset), .req(req), .instr(instr), .pc(pc),
		.ack(ack), .result(result), .next_pc(next_pc), .taken(taken), .illegal(illegal)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, exec_pkg::op_reg};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	// Offsets are in bytes and the format drops bit 0
	function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], exec_pkg::op_branch};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, exec_pkg::op_jal};
	endfunction

	// Fibonacci LFSR on x^17 + x^14 + 1 that steps once per bit taken
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking and handshake
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input logic [31:0] word, input logic [31:0] at_pc,
		input logic [31:0] res, input logic [31:0] npc, input logic tk, input logic ill);
		table_instr.push_back(word);
		table_pc.push_back(at_pc);
		table_result.push_back(res);
		table_next_pc.push_back(npc);
		table_taken.push_back(tk);
		table_illegal.push_back(ill);
	endtask

	// Samples 2 ns after each rising edge until ack reaches the level
	task automatic wait_for_ack(input logic level, output logic seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < ack_timeout) begin
			@(posedge clock);
			#2;
			cycles++;
			if (ack === level)
				seen = 1'b1;
		end
	endtask

	task automatic run_entry(input int idx, input int hold);
		logic       seen;
		logic [1:0] gap;
		int         k;
		instr = table_instr[idx];
		pc    = table_pc[idx];
		req   = 1'b1;
		wait_for_ack(1'b1, seen);
		if (!seen) begin
			errors++;
			$display("Timeout: ack never rose for table entry %0d", idx);
		end else begin
			check_value($sformatf("entry %0d result", idx), result, table_result[idx]);
			check_value($sformatf("entry %0d next_pc", idx), next_pc, table_next_pc[idx]);
			check_value($sformatf("entry %0d taken", idx), {31'b0, taken},
				{31'b0, table_taken[idx]});
			check_value($sformatf("entry %0d illegal", idx), {31'b0, illegal},
				{31'b0, table_illegal[idx]});
			// The requester stalls here and the core must keep everything frozen
			for (k = 0; k < hold; k++) begin
				@(posedge clock);
				#2;
				check_value($sformatf("entry %0d ack while held", idx), {31'b0, ack}, 32'd1);
				check_value($sformatf("entry %0d result while held", idx), result,
					table_result[idx]);
				check_value($sformatf("entry %0d next_pc while held", idx), next_pc,
					table_next_pc[idx]);
				check_value($sformatf("entry %0d taken while held", idx), {31'b0, taken},
					{31'b0, table_taken[idx]});
				check_value($sformatf("entry %0d illegal while held", idx), {31'b0, illegal},
					{31'b0, table_illegal[idx]});
			end
		end
		req = 1'b0;
		wait_for_ack(1'b0, seen);
		if (!seen) begin
			errors++;
			$display("Timeout: ack stayed high after req fell for table entry %0d", idx);
		end
		gap = 2'b0;
		for (k = 0; k < 2; k++) begin
			gap  = {gap[0], lfsr[16]};
			lfsr = lfsr_next(lfsr);
		end
		repeat (gap) begin
			@(posedge clock);
			#2;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program with expected values worked out in table order
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// Constants first and then register-register arithmetic on them
		add_entry(i_format(12'h005, 5'd0, 3'b000, 5'd1, exec_pkg::op_imm),
			32'h100, 32'h5, 32'h104, 1'b0, 1'b0);
		add_entry(i_format(12'hffd, 5'd0, 3'b000, 5'd2, exec_pkg::op_imm),
			32'h104, 32'hfffffffd, 32'h108, 1'b0, 1'b0);
		add_entry(i_format(12'h123, 5'd0, 3'b000, 5'd3, exec_pkg::op_imm),
			32'h108, 32'h123, 32'h10c, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd4),
			32'h10c, 32'h2, 32'h110, 1'b0, 1'b0);
		add_entry(r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd5),
			32'h110, 32'h8, 32'h114, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd3, 5'd2, 3'b111, 5'd6),
			32'h114, 32'h121, 32'h118, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd3, 5'd1, 3'b110, 5'd7),
			32'h118, 32'h127, 32'h11c, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd3, 5'd1, 3'b100, 5'd8),
			32'h11c, 32'h126, 32'h120, 1'b0, 1'b0);
		// A shift by -3 is a shift by 29 and a shift by 36 is a shift by 4
		add_entry(r_format(7'h00, 5'd2, 5'd1, 3'b001, 5'd9),
			32'h120, 32'ha0000000, 32'h124, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd2, 5'd9, 3'b101, 5'd10),
			32'h124, 32'h5, 32'h128, 1'b0, 1'b0);
		add_entry(r_format(7'h20, 5'd2, 5'd9, 3'b101, 5'd11),
			32'h128, 32'hfffffffd, 32'h12c, 1'b0, 1'b0);
		add_entry(i_format(12'h024, 5'd0, 3'b000, 5'd12, exec_pkg::op_imm),
			32'h12c, 32'h24, 32'h130, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd12, 5'd9, 3'b101, 5'd13),
			32'h130, 32'h0a000000, 32'h134, 1'b0, 1'b0);
		add_entry(i_format(12'h404, 5'd9, 3'b101, 5'd14, exec_pkg::op_imm),
			32'h134, 32'hfa000000, 32'h138, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd1, 5'd2, 3'b010, 5'd15),
			32'h138, 32'h1, 32'h13c, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd1, 5'd2, 3'b011, 5'd16),
			32'h13c, 32'h0, 32'h140, 1'b0, 1'b0);
		// Upper immediates and jumps
		add_entry(u_format(20'h12345, 5'd17, exec_pkg::op_lui),
			32'h140, 32'h12345000, 32'h144, 1'b0, 1'b0);
		add_entry(u_format(20'h00001, 5'd18, exec_pkg::op_auipc),
			32'h144, 32'h1144, 32'h148, 1'b0, 1'b0);
		add_entry(j_format(21'h000040, 5'd19),
			32'h200, 32'h204, 32'h240, 1'b1, 1'b0);
		add_entry(i_format(12'h020, 5'd5, 3'b000, 5'd20, exec_pkg::op_jalr),
			32'h240, 32'h244, 32'h28, 1'b1, 1'b0);
		// Each branch condition taken and then not taken
		add_entry(b_format(13'h0010, 5'd1, 5'd1, 3'b000),
			32'h300, 32'h0, 32'h310, 1'b1, 1'b0);
		add_entry(b_format(13'h0010, 5'd2, 5'd1, 3'b000),
			32'h304, 32'h0, 32'h308, 1'b0, 1'b0);
		add_entry(b_format(13'h0010, 5'd2, 5'd1, 3'b001),
			32'h308, 32'h0, 32'h318, 1'b1, 1'b0);
		add_entry(b_format(13'h0010, 5'd1, 5'd1, 3'b001),
			32'h30c, 32'h0, 32'h310, 1'b0, 1'b0);
		add_entry(b_format(13'h0010, 5'd1, 5'd2, 3'b100),
			32'h310, 32'h0, 32'h320, 1'b1, 1'b0);
		add_entry(b_format(13'h0010, 5'd2, 5'd1, 3'b100),
			32'h314, 32'h0, 32'h318, 1'b0, 1'b0);
		add_entry(b_format(13'h0010, 5'd2, 5'd1, 3'b101),
			32'h318, 32'h0, 32'h328, 1'b1, 1'b0);
		add_entry(b_format(13'h0010, 5'd1, 5'd2, 3'b101),
			32'h31c, 32'h0, 32'h320, 1'b0, 1'b0);
		add_entry(b_format(13'h1fe0, 5'd2, 5'd1, 3'b110),
			32'h320, 32'h0, 32'h300, 1'b1, 1'b0);
		add_entry(b_format(13'h1fe0, 5'd1, 5'd2, 3'b110),
			32'h324, 32'h0, 32'h328, 1'b0, 1'b0);
		add_entry(b_format(13'h0010, 5'd1, 5'd2, 3'b111),
			32'h328, 32'h0, 32'h338, 1'b1, 1'b0);
		add_entry(b_format(13'h0010, 5'd2, 5'd1, 3'b111),
			32'h32c, 32'h0, 32'h330, 1'b0, 1'b0);
		// Scratch CSR accesses and one to the unimplemented 0x341
		add_entry(i_format(exec_pkg::csr_scratch_addr, 5'd1, 3'b001, 5'd21, exec_pkg::op_system),
			32'h330, 32'h0, 32'h334, 1'b0, 1'b0);
		add_entry(i_format(exec_pkg::csr_scratch_addr, 5'd3, 3'b010, 5'd22, exec_pkg::op_system),
			32'h334, 32'h5, 32'h338, 1'b0, 1'b0);
		add_entry(i_format(12'h341, 5'd2, 3'b001, 5'd23, exec_pkg::op_system),
			32'h338, 32'h0, 32'h33c, 1'b0, 1'b0);
		add_entry(i_format(exec_pkg::csr_scratch_addr, 5'd0, 3'b010, 5'd24, exec_pkg::op_system),
			32'h33c, 32'h127, 32'h340, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd22, 5'd21, 3'b000, 5'd25),
			32'h340, 32'h5, 32'h344, 1'b0, 1'b0);
		// x0 stays zero and a load is refused without touching x27
		add_entry(i_format(12'h007, 5'd1, 3'b000, 5'd0, exec_pkg::op_imm),
			32'h344, 32'hc, 32'h348, 1'b0, 1'b0);
		add_entry(r_format(7'h00, 5'd1, 5'd0, 3'b000, 5'd26),
			32'h348, 32'h5, 32'h34c, 1'b0, 1'b0);
		add_entry(i_format(12'h000, 5'd1, 3'b010, 5'd27, 7'b0000011),
			32'h34c, 32'h0, 32'h350, 1'b0, 1'b1);
		add_entry(r_format(7'h00, 5'd1, 5'd27, 3'b000, 5'd28),
			32'h350, 32'h5, 32'h354, 1'b0, 1'b0);
	endtask

	initial begin
		int i;
		req    = 1'b0;
		instr  = 32'b0;
		pc     = 32'b0;
		reset  = 1'b1;
		errors = 0;
		checks = 0;
		lfsr   = 17'd65804;
		build_table();
		repeat (3) @(posedge clock);
		#2 reset = 1'b0;
		check_value("ack after reset", {31'b0, ack}, 32'd0);
		check_value("result after reset", result, 32'd0);
		for (i = 0; i < table_instr.size(); i++)
			run_entry(i, (i % 10 == 0) ? 3 : 0); // Every tenth requester stalls
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/exec_pkg.sv
rtl/exec_control.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/csr_file.sv
rtl/exec_core.sv
bench/exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -f sources.f --top-module exec_core_tb -o exec_core_sim &&
./obj_dir/exec_core_sim | grep "Result: PASSED" ||
{ echo "Simulation did not pass"; exit 1; }
